/* src.f */
verilog/telemetry_pkg.sv
verilog/hex_line_formatter.sv
verilog/char_fifo.sv
verilog/uart_tx.sv
verilog/telemetry_uart_top.sv
verification/tb_clock_gen.sv
verification/telemetry_uart_tb.sv

/* Bender.yml */
package:
  name: telemetry_uart

sources:
  - verilog/telemetry_pkg.sv
  - verilog/hex_line_formatter.sv
  - verilog/char_fifo.sv
  - verilog/uart_tx.sv
  - verilog/telemetry_uart_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/telemetry_uart_tb.sv

/* verification/telemetry_uart_tb.sv */
// ########################################
// telemetry UART testbench
// random snapshots, serial decoder and reference check
// ########################################

module telemetry_uart_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD      = 100;
	localparam int DRIVE_DELAY     = 10;
	localparam int FRAME_CHARS     = telemetry_pkg::TELEM_WORDS * telemetry_pkg::CHARS_PER_LINE;
	localparam int CHAR_CYCLES     = 10 * telemetry_pkg::CLKS_PER_BIT;
	localparam int WATCHDOG_CYCLES = 3 * FRAME_CHARS * CHAR_CYCLES + 20000;
	localparam int BUSY_START_GAP  = 41;  // spacing of start pulses during a frame

	logic                      clk;
	logic                      resetn;
	logic                      start;
	telemetry_pkg::telemetry_t telemetry;
	logic                      sout;
	logic                      frame_busy;

	integer                    seed;
	logic                      started = 1'b0;
	telemetry_pkg::ascii_t     exp_q[$];     // expected character stream
	int                        rx_count = 0;
	int                        err_value = 0;
	int                        err_framing = 0;
	int                        err_protocol = 0;

	tb_clock_gen i_clock_gen (
		.clk_o    (clk),
		.resetn_o (resetn)
	);

	telemetry_uart_top i_dut (
		.clk          (clk),
		.resetn       (resetn),
		.start_i      (start),
		.telemetry_i  (telemetry),
		.sout_o       (sout),
		.frame_busy_o (frame_busy)
	);

	function automatic telemetry_pkg::ascii_t hex_ascii(logic [3:0] n);
		string digits;
		digits = "0123456789ABCDEF";
		return digits[n];
	endfunction

	// packed fields walked down from the msb
	function automatic telemetry_pkg::telem_word_t field_value(telemetry_pkg::telemetry_t t,
	                                                           int k);
		logic [$bits(telemetry_pkg::telemetry_t)-1:0] flat;
		int top;
		int width;
		flat  = t;
		top   = $bits(telemetry_pkg::telemetry_t);
		width = 16;
		for (int i = 0; i <= k; i++) begin
			width = (i >= 7 && i <= 13) ? 8 : 16; // receiver channels are bytes
			top   = top - width;
		end
		flat = flat >> top;
		return (width == 8) ? {8'h00, flat[7:0]} : flat[15:0];
	endfunction

	function automatic telemetry_pkg::telemetry_t random_telemetry();
		logic [255:0] raw;
		for (int i = 0; i < 8; i++)
			raw[i*32 +: 32] = $random(seed);
		return raw[$bits(telemetry_pkg::telemetry_t)-1:0];
	endfunction

	// one line per word with index, value, LF and CR
	function automatic void append_frame(telemetry_pkg::telemetry_t t);
		telemetry_pkg::telem_word_t w;
		logic [7:0] idx;
		for (int k = 0; k < telemetry_pkg::TELEM_WORDS; k++) begin
			w   = field_value(t, k);
			idx = 8'(k);
			exp_q.push_back(hex_ascii(idx[7:4]));
			exp_q.push_back(hex_ascii(idx[3:0]));
			for (int n = 3; n >= 0; n--)
				exp_q.push_back(hex_ascii(w[n*4 +: 4]));
			exp_q.push_back(8'h0A);
			exp_q.push_back(8'h0D);
		end
	endfunction

	task automatic start_frame();
		@(posedge clk);
		#(DRIVE_DELAY);
		telemetry = random_telemetry();
		start     = 1'b1;
		started   = 1'b1;
		append_frame(telemetry); // values present on the start edge
		@(posedge clk);
		#(DRIVE_DELAY);
		start = 1'b0;
	endtask

	// new telemetry every cycle and start pulses that must be ignored
	task automatic scramble_while_busy();
		int cycle;
		cycle = 0;
		while (frame_busy) begin
			telemetry = random_telemetry();
			start     = (cycle % BUSY_START_GAP == 7);
			cycle++;
			@(posedge clk);
			#(DRIVE_DELAY);
		end
		start = 1'b0;
	endtask

	task automatic run_frame(int total_chars);
		start_frame();
		scramble_while_busy();
		wait (rx_count >= total_chars);
		repeat (2 * CHAR_CYCLES) @(posedge clk); // line must stay quiet now
		assert (rx_count == total_chars) else begin
			err_protocol++;
			$display("expected %0d characters in total but %0d arrived", total_chars, rx_count);
		end
		assert (!frame_busy) else begin
			err_protocol++;
			$display("formatter still busy after the frame was sent");
		end
	endtask

	assert property (@(negedge clk) (!started && !$isunknown(resetn)) |-> sout === 1'b1)
		else begin
			err_value++;
			$display("error sout: expected 1 received %h", $sampled(sout));
		end

	assert property (@(negedge clk) (!started && !$isunknown(resetn)) |-> frame_busy === 1'b0)
		else begin
			err_value++;
			$display("error frame_busy: expected 0 received %h", $sampled(frame_busy));
		end

	assert property (@(posedge clk) disable iff (!resetn) (start && !frame_busy) |=> frame_busy)
		else begin
			err_protocol++;
			$display("frame_busy did not rise one cycle after an accepted start");
		end

	assert property (@(posedge clk) disable iff (!resetn) $rose(frame_busy) |-> $past(start))
		else begin
			err_protocol++;
			$display("frame_busy rose without a start in the cycle before");
		end

	// serial decoder sampling each bit at its centre
	initial begin
		logic [9:0] bits;
		logic first;
		logic stable;
		telemetry_pkg::ascii_t ch;
		forever begin
			@(negedge clk);
			if (resetn === 1'b1 && sout === 1'b0) begin
				for (int i = 0; i < 10; i++) begin
					first  = sout;
					stable = 1'b1;
					for (int c = 1; c < telemetry_pkg::CLKS_PER_BIT; c++) begin
						@(negedge clk);
						if (sout !== first)
							stable = 1'b0;
						if (c == telemetry_pkg::CLKS_PER_BIT / 2)
							bits[i] = sout;
					end
					assert (stable) else begin
						err_framing++;
						$display("bit %0d of character %0d did not last %0d cycles",
						         i, rx_count, telemetry_pkg::CLKS_PER_BIT);
					end
					if (i < 9)
						@(negedge clk);
				end
				assert (bits[0] == 1'b0) else begin
					err_framing++;
					$display("error sout start bit: expected 0 received %h", bits[0]);
				end
				assert (bits[9] == 1'b1) else begin
					err_framing++;
					$display("error sout stop bit: expected 1 received %h", bits[9]);
				end
				ch = bits[8:1]; // lsb first on the wire
				assert (rx_count < exp_q.size()) else begin
					err_value++;
					$display("unexpected character %h arrived after the last frame", ch);
				end
				if (rx_count < exp_q.size()) begin
					assert (ch == exp_q[rx_count]) else begin
						err_value++;
						$display("error sout char %0d: expected %h received %h",
						         rx_count, exp_q[rx_count], ch);
					end
				end
				rx_count++;
			end
		end
	end

	initial begin
		seed      = 32'hc40d0a6d;
		start     = 1'b0;
		telemetry = '0;
		@(posedge resetn);
		repeat (4) @(posedge clk);
		run_frame(FRAME_CHARS);
		run_frame(2 * FRAME_CHARS); // index restarts at 00
		$display("summary: value errors %0d, framing errors %0d, protocol errors %0d",
		         err_value, err_framing, err_protocol);
		if (err_value + err_framing + err_protocol == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// three frames of serial time plus margin
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles before the stream completed",
		         WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

/* verification/tb_clock_gen.sv */
// ########################################
// testbench clock and reset source
// ########################################

module tb_clock_gen (
	output logic clk_o,
	output logic resetn_o
);

	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	initial begin
		resetn_o = 1'b0;
		repeat (3) @(posedge clk_o); // three cycles in reset
		#10 resetn_o = 1'b1;
	end

endmodule

/* verilog/telemetry_uart_top.sv */
// ########################################
// telemetry UART dumper, top level
// formatter -> char FIFO -> 8N1 transmitter
// ########################################

module telemetry_uart_top (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        start_i,
	input  telemetry_pkg::telemetry_t   telemetry_i,
	output logic                        sout_o,
	output logic                        frame_busy_o
);

	logic                   push;
	telemetry_pkg::ascii_t  push_char;
	logic                   full;
	logic                   empty;
	logic                   pop;
	telemetry_pkg::ascii_t  pop_char;

	hex_line_formatter i_formatter (
		.clk          (clk),
		.resetn       (resetn),
		.start_i      (start_i),
		.telemetry_i  (telemetry_i),
		.fifo_full_i  (full),
		.push_o       (push),
		.push_char_o  (push_char),
		.frame_busy_o (frame_busy_o)
	);

	char_fifo i_fifo (
		.clk         (clk),
		.resetn      (resetn),
		.push_i      (push),
		.push_char_i (push_char),
		.pop_i       (pop),
		.full_o      (full),
		.empty_o     (empty),
		.pop_char_o  (pop_char)
	);

	uart_tx i_uart_tx (
		.clk          (clk),
		.resetn       (resetn),
		.fifo_empty_i (empty),
		.pop_char_i   (pop_char),
		.pop_o        (pop),
		.sout_o       (sout_o)
	);

endmodule

/* verilog/uart_tx.sv */
// ########################################
// UART transmitter, 8N1
// pops characters and shifts them out lsb first
// ########################################

module uart_tx (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    fifo_empty_i,
	input  telemetry_pkg::ascii_t   pop_char_i,
	output logic                    pop_o,
	output logic                    sout_o
);

	telemetry_pkg::tx_state_e               state;
	logic [telemetry_pkg::BAUD_CNT_W-1:0]   baud_cnt;
	logic [2:0]                             bit_cnt;
	telemetry_pkg::ascii_t                  shift_q;
	logic                                   bit_end;
	logic                                   sout_q;

	assign bit_end = (baud_cnt == telemetry_pkg::BAUD_CNT_W'(telemetry_pkg::CLKS_PER_BIT - 1));

	// idle, or last cycle of stop bit for back to back frames
	assign pop_o = !fifo_empty_i
	            && ((state == telemetry_pkg::TX_IDLE)
	             || (state == telemetry_pkg::TX_STOP && bit_end));

	assign sout_o = sout_q;

	// data shifter
	always_ff @(posedge clk) begin
		if (pop_o)
			shift_q <= pop_char_i;
		else if (state == telemetry_pkg::TX_DATA && bit_end)
			shift_q <= shift_q >> 1;
	end

	// baud timer, restarts on every bit boundary
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn)
			baud_cnt <= '0;
		else if (state == telemetry_pkg::TX_IDLE || bit_end)
			baud_cnt <= '0;
		else
			baud_cnt <= baud_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state   <= telemetry_pkg::TX_IDLE;
			bit_cnt <= '0;
			sout_q  <= 1'b1; // line idles high
		end else begin
			case (state)
				telemetry_pkg::TX_IDLE: begin
					if (pop_o) begin
						state  <= telemetry_pkg::TX_START;
						sout_q <= 1'b0;
					end
				end
				telemetry_pkg::TX_START: begin
					if (bit_end) begin
						state   <= telemetry_pkg::TX_DATA;
						bit_cnt <= '0;
						sout_q  <= shift_q[0];
					end
				end
				telemetry_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							state  <= telemetry_pkg::TX_STOP;
							sout_q <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							sout_q  <= shift_q[1]; // next bit after the shift
						end
					end
				end
				telemetry_pkg::TX_STOP: begin
					if (bit_end) begin
						state  <= pop_o ? telemetry_pkg::TX_START : telemetry_pkg::TX_IDLE;
						sout_q <= !pop_o;
					end
				end
				default: state <= telemetry_pkg::TX_IDLE;
			endcase
		end
	end

endmodule

/* verilog/char_fifo.sv */
// ########################################
// character FIFO
// synchronous, full and empty flags
// ########################################

module char_fifo (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    push_i,
	input  telemetry_pkg::ascii_t   push_char_i,
	input  logic                    pop_i,
	output logic                    full_o,
	output logic                    empty_o,
	output telemetry_pkg::ascii_t   pop_char_o
);

	telemetry_pkg::ascii_t mem [telemetry_pkg::FIFO_DEPTH];

	// extra msb tells a wrapped writer from an equal address
	logic [telemetry_pkg::FIFO_AW:0]   wr_ptr;
	logic [telemetry_pkg::FIFO_AW:0]   rd_ptr;
	logic [telemetry_pkg::FIFO_AW-1:0] wr_addr;
	logic [telemetry_pkg::FIFO_AW-1:0] rd_addr;

	assign wr_addr = wr_ptr[telemetry_pkg::FIFO_AW-1:0];
	assign rd_addr = rd_ptr[telemetry_pkg::FIFO_AW-1:0];

	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr[telemetry_pkg::FIFO_AW] != rd_ptr[telemetry_pkg::FIFO_AW])
	              && (wr_addr == rd_addr);

	assign pop_char_o = mem[rd_addr]; // head, valid while not empty

	// storage
	always_ff @(posedge clk) begin
		if (push_i)
			mem[wr_addr] <= push_char_i;
	end

	// pointers move independently, push and pop may coincide
	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

/* verilog/hex_line_formatter.sv */
// ########################################
// hex line formatter
// snapshots telemetry, pushes one ASCII line per word
// ########################################

module hex_line_formatter (
	input  logic                        clk,
	input  logic                        resetn,
	input  logic                        start_i,
	input  telemetry_pkg::telemetry_t   telemetry_i,
	input  logic                        fifo_full_i,
	output logic                        push_o,
	output telemetry_pkg::ascii_t       push_char_o,
	output logic                        frame_busy_o
);

	telemetry_pkg::fmt_state_e             state;
	telemetry_pkg::telemetry_t             snap;
	telemetry_pkg::word_index_t            word_idx;
	logic [telemetry_pkg::CHAR_IDX_W-1:0]  char_idx;
	telemetry_pkg::telem_word_t            cur_word;
	logic                                  start_take;
	logic                                  last_char;
	logic                                  last_word;

	// nibble to upper-case hex digit
	function automatic telemetry_pkg::ascii_t hex_digit(input logic [3:0] nib);
		telemetry_pkg::ascii_t c;
		if (nib < 4'd10)
			c = 8'h30 + {4'h0, nib};         // '0'..'9'
		else
			c = 8'h41 + {4'h0, nib} - 8'd10; // 'A'..'F'
		return c;
	endfunction

	assign start_take   = (state == telemetry_pkg::FMT_IDLE) && start_i;
	assign push_o       = (state == telemetry_pkg::FMT_EMIT) && !fifo_full_i;
	assign frame_busy_o = (state != telemetry_pkg::FMT_IDLE);
	assign last_char    = (char_idx == telemetry_pkg::CHAR_IDX_W'(telemetry_pkg::CHARS_PER_LINE - 1));
	assign last_word    = (word_idx == telemetry_pkg::word_index_t'(telemetry_pkg::TELEM_WORDS - 1));

	// snapshot only on an accepted start
	always_ff @(posedge clk) begin
		if (start_take)
			snap <= telemetry_i;
	end

	// word mux, receiver channels padded with zeros
	always_comb begin
		case (word_idx)
			8'd0:    cur_word = snap.imu_x_rot_angle;
			8'd1:    cur_word = snap.imu_y_rot_angle;
			8'd2:    cur_word = snap.imu_z_rot_angle;
			8'd3:    cur_word = snap.imu_x_rot_rate;
			8'd4:    cur_word = snap.imu_y_rot_rate;
			8'd5:    cur_word = snap.imu_z_rot_rate;
			8'd6:    cur_word = snap.imu_cal_status;
			8'd7:    cur_word = {8'h00, snap.rc_throttle};
			8'd8:    cur_word = {8'h00, snap.rc_yaw};
			8'd9:    cur_word = {8'h00, snap.rc_roll};
			8'd10:   cur_word = {8'h00, snap.rc_pitch};
			8'd11:   cur_word = {8'h00, snap.rc_aux1};
			8'd12:   cur_word = {8'h00, snap.rc_aux2};
			8'd13:   cur_word = {8'h00, snap.rc_switches};
			8'd14:   cur_word = snap.yaw_angle_error;
			8'd15:   cur_word = snap.yaw_angle_target;
			8'd16:   cur_word = snap.z_linear_velocity;
			8'd17:   cur_word = snap.debug0;
			8'd18:   cur_word = snap.debug1;
			default: cur_word = '0;
		endcase
	end

	// character within the line
	always_comb begin
		case (char_idx)
			3'd0:    push_char_o = hex_digit(word_idx[7:4]);
			3'd1:    push_char_o = hex_digit(word_idx[3:0]);
			3'd2:    push_char_o = hex_digit(cur_word[15:12]);
			3'd3:    push_char_o = hex_digit(cur_word[11:8]);
			3'd4:    push_char_o = hex_digit(cur_word[7:4]);
			3'd5:    push_char_o = hex_digit(cur_word[3:0]);
			3'd6:    push_char_o = telemetry_pkg::ASCII_LF;
			default: push_char_o = telemetry_pkg::ASCII_CR;
		endcase
	end

	always_ff @(posedge clk or negedge resetn) begin
		if (!resetn) begin
			state    <= telemetry_pkg::FMT_IDLE;
			word_idx <= '0;
			char_idx <= '0;
		end else begin
			case (state)
				telemetry_pkg::FMT_IDLE: begin
					if (start_i) begin
						state    <= telemetry_pkg::FMT_EMIT;
						word_idx <= '0;
						char_idx <= '0;
					end
				end
				telemetry_pkg::FMT_EMIT: begin
					if (push_o) begin // stalls here while FIFO is full
						char_idx <= last_char ? '0 : char_idx + 1'b1;
						if (last_char)
							state <= telemetry_pkg::FMT_NEXT_WORD;
					end
				end
				telemetry_pkg::FMT_NEXT_WORD: begin
					if (last_word) begin
						state <= telemetry_pkg::FMT_IDLE;
					end else begin
						word_idx <= word_idx + 1'b1;
						state    <= telemetry_pkg::FMT_EMIT;
					end
				end
				default: state <= telemetry_pkg::FMT_IDLE;
			endcase
		end
	end

endmodule

/* verilog/telemetry_pkg.sv */
// ########################################
// telemetry package
// widths, frame constants, snapshot struct and FSM states
// ########################################

package telemetry_pkg;

	// printed widths
	typedef logic [15:0] telem_word_t;
	typedef logic [7:0]  rc_val_t;      // receiver channel, zero-extended on print
	typedef logic [7:0]  ascii_t;
	typedef logic [7:0]  word_index_t;  // printed as two hex digits

	// frame layout
	localparam int TELEM_WORDS    = 19;
	localparam int CHARS_PER_LINE = 8;  // 2 index + 4 value + LF + CR
	localparam int CHAR_IDX_W     = $clog2(CHARS_PER_LINE);

	localparam ascii_t ASCII_LF = 8'h0A;
	localparam ascii_t ASCII_CR = 8'h0D;

	// character buffer
	localparam int FIFO_DEPTH = 16;     // keep a power of two
	localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

	// 10 MHz clock, 115200 baud
	localparam int CLKS_PER_BIT = 87;
	localparam int BAUD_CNT_W   = $clog2(CLKS_PER_BIT);

	// fields in print order, first field is line 00
	typedef struct packed {
		telem_word_t imu_x_rot_angle;
		telem_word_t imu_y_rot_angle;
		telem_word_t imu_z_rot_angle;
		telem_word_t imu_x_rot_rate;
		telem_word_t imu_y_rot_rate;
		telem_word_t imu_z_rot_rate;
		telem_word_t imu_cal_status;
		rc_val_t     rc_throttle;
		rc_val_t     rc_yaw;
		rc_val_t     rc_roll;
		rc_val_t     rc_pitch;
		rc_val_t     rc_aux1;
		rc_val_t     rc_aux2;
		rc_val_t     rc_switches;
		telem_word_t yaw_angle_error;
		telem_word_t yaw_angle_target;
		telem_word_t z_linear_velocity;
		telem_word_t debug0;
		telem_word_t debug1;
	} telemetry_t;

	typedef enum logic [1:0] {FMT_IDLE, FMT_EMIT, FMT_NEXT_WORD} fmt_state_e;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage
